// ==== logic/armPkg.sv ====
// Shared widths, typedefs, control enums and instruction field constants for the ARM core
package armPkg;

   typedef logic [31:0] word_t;     // Data word, address or instruction
   typedef logic [3:0]  regAddr_t;  // Register index
   typedef logic [3:0]  cond_t;     // Condition field
   typedef logic [3:0]  flags_t;    // N, Z, C, V from bit 3 down

   typedef enum logic [1:0] {
      aluAnd = 2'b00,
      aluSub = 2'b01,  // Inverts operand b and sets carry-in
      aluAdd = 2'b10,
      aluOrr = 2'b11
   } aluOp_t;

   typedef enum logic [1:0] {
      immDp8      = 2'b00,  // Zero-extended data-processing immediate
      immMem12    = 2'b01,  // Zero-extended load/store offset
      immBranch24 = 2'b10   // Sign-extended word offset
   } immSrc_t;

   typedef enum logic [1:0] {
      opDataProc = 2'b00,
      opMemory   = 2'b01,
      opBranch   = 2'b10
   } opClass_t;

   localparam regAddr_t pcRegIdx   = 4'd15;
   localparam cond_t    condAlways = 4'b1110;
   localparam word_t    pcStep     = 32'd4;

   // Data-processing function codes in Instr[24:21]
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functOrr = 4'b1100;

   // Instruction field positions
   localparam int condMsb  = 31;
   localparam int condLsb  = 28;
   localparam int opMsb    = 27;
   localparam int opLsb    = 26;
   localparam int iBit     = 25;  // Immediate operand
   localparam int functMsb = 24;
   localparam int functLsb = 21;
   localparam int sBit     = 20;  // Set flags on data processing
   localparam int lBit     = 20;  // Load versus store
   localparam int rnMsb    = 19;
   localparam int rnLsb    = 16;
   localparam int rdMsb    = 15;
   localparam int rdLsb    = 12;
   localparam int rmMsb    = 3;
   localparam int rmLsb    = 0;
   localparam int imm8Msb  = 7;
   localparam int imm12Msb = 11;
   localparam int imm24Msb = 23;

endpackage

// ==== logic/alu.sv ====
// ALU for AND, ORR, ADD and SUB with N, Z, C and V generation
`timescale 1ns/1ps

module alu (
   input  armPkg::word_t  a,
   input  armPkg::word_t  b,
   input  armPkg::aluOp_t ALUControl,
   output armPkg::word_t  Result,
   output armPkg::flags_t ALUFlags
);

   logic          subtract;
   logic          arith;     // Add or subtract
   armPkg::word_t condInvB;
   logic [32:0]   sum;       // Carry out in bit 32
   logic          neg, zero, carry, overflow;

   assign subtract = (ALUControl == armPkg::aluSub);
   assign arith    = (ALUControl == armPkg::aluAdd) | subtract;

   // Subtraction as a + ~b + 1
   assign condInvB = subtract ? ~b : b;
   assign sum      = {1'b0, a} + {1'b0, condInvB} + {32'b0, subtract};

   always_comb
   begin
      case (ALUControl)
         armPkg::aluAnd: Result = a & b;
         armPkg::aluOrr: Result = a | b;
         default:        Result = sum[31:0];  // Add and sub share the adder
      endcase
   end

   assign neg      = Result[31];
   assign zero     = (Result == '0);
   assign carry    = arith & sum[32];
   // Operands of equal effective sign, result sign differs
   assign overflow = arith & ~(a[31] ^ b[31] ^ subtract) & (a[31] ^ sum[31]);
   assign ALUFlags = {neg, zero, carry, overflow};

endmodule

// ==== logic/regFile.sv ====
// Fifteen-entry register file with R15 reading as PC+8
`timescale 1ns/1ps

module regFile (
   input  logic             clk,
   input  logic             we,
   input  armPkg::regAddr_t ra1,
   input  armPkg::regAddr_t ra2,
   input  armPkg::regAddr_t wa,
   input  armPkg::word_t    wd,
   input  armPkg::word_t    r15,
   output armPkg::word_t    rd1,
   output armPkg::word_t    rd2
);

   armPkg::word_t regs [0:14];  // R0 to R14

   // R15 has no storage, its writes are jumps handled by pcUnit
   always_ff @(posedge clk)
   begin
      if (we && wa != armPkg::pcRegIdx)
         regs[wa] <= wd;
   end

   assign rd1 = (ra1 == armPkg::pcRegIdx) ? r15 : regs[ra1];
   assign rd2 = (ra2 == armPkg::pcRegIdx) ? r15 : regs[ra2];

endmodule

// ==== logic/datapath.sv ====
// Datapath with register addressing, immediate extension, operand and result muxes
`timescale 1ns/1ps

module datapath (
   input  logic            clk,
   input  armPkg::word_t   Instr,
   input  armPkg::word_t   ReadData,
   input  armPkg::word_t   PCPlus8,
   input  logic            RegWrite,
   input  logic [1:0]      RegSrc,
   input  armPkg::immSrc_t ImmSrc,
   input  logic            ALUSrc,
   input  armPkg::aluOp_t  ALUControl,
   input  logic            MemtoReg,
   output armPkg::flags_t  ALUFlags,
   output armPkg::word_t   ALUResult,
   output armPkg::word_t   WriteData,
   output armPkg::word_t   Result
);

   armPkg::regAddr_t ra1, ra2, wa;
   armPkg::word_t    srcA, srcB;
   armPkg::word_t    extImm;

   // Branch takes PC+8 as base, store reads rd as its data
   assign ra1 = RegSrc[0] ? armPkg::pcRegIdx : Instr[armPkg::rnMsb:armPkg::rnLsb];
   assign ra2 = RegSrc[1] ? Instr[armPkg::rdMsb:armPkg::rdLsb]
                          : Instr[armPkg::rmMsb:armPkg::rmLsb];
   assign wa  = Instr[armPkg::rdMsb:armPkg::rdLsb];

   regFile rf (
      .clk (clk),
      .we  (RegWrite),
      .ra1 (ra1),
      .ra2 (ra2),
      .wa  (wa),
      .wd  (Result),
      .r15 (PCPlus8),
      .rd1 (srcA),
      .rd2 (WriteData)
   );

   always_comb
   begin
      case (ImmSrc)
         armPkg::immDp8:      extImm = {24'b0, Instr[armPkg::imm8Msb:0]};
         armPkg::immMem12:    extImm = {20'b0, Instr[armPkg::imm12Msb:0]};
         // Word offset, sign extended and shifted by two
         armPkg::immBranch24: extImm = {{6{Instr[armPkg::imm24Msb]}},
                                        Instr[armPkg::imm24Msb:0], 2'b00};
         default:             extImm = '0;
      endcase
   end

   assign srcB = ALUSrc ? extImm : WriteData;

   alu alu (
      .a          (srcA),
      .b          (srcB),
      .ALUControl (ALUControl),
      .Result     (ALUResult),
      .ALUFlags   (ALUFlags)
   );

   assign Result = MemtoReg ? ReadData : ALUResult;  // Write-back and jump target

endmodule

// ==== logic/decoder.sv ====
// Main decoder and ALU decoder producing raw control from the instruction word
`timescale 1ns/1ps

module decoder (
   input  armPkg::word_t   Instr,
   output logic [1:0]      FlagW,      // NZ enable, CV enable
   output logic            PCS,
   output logic            RegW,
   output logic            MemW,
   output logic            MemtoReg,
   output logic            ALUSrc,
   output logic            MemStrobe,
   output armPkg::immSrc_t ImmSrc,
   output armPkg::aluOp_t  ALUControl,
   output logic [1:0]      RegSrc      // [0] R15 as base, [1] rd as second read
);

   armPkg::opClass_t op;
   logic [3:0]       funct;
   logic             functKnown;  // One of the four supported operations
   logic             setFlags;
   logic             branch;

   assign op    = armPkg::opClass_t'(Instr[armPkg::opMsb:armPkg::opLsb]);
   assign funct = Instr[armPkg::functMsb:armPkg::functLsb];

   always_comb
   begin
      // Defaults describe a no-op
      RegW       = 1'b0;
      MemW       = 1'b0;
      MemtoReg   = 1'b0;
      ALUSrc     = 1'b0;
      MemStrobe  = 1'b0;
      ImmSrc     = armPkg::immDp8;
      ALUControl = armPkg::aluAdd;  // Address and branch target use add
      RegSrc     = 2'b00;
      FlagW      = 2'b00;
      branch     = 1'b0;
      functKnown = 1'b1;
      setFlags   = 1'b0;
      case (op)
         armPkg::opDataProc:
         begin
            ALUSrc = Instr[armPkg::iBit];
            case (funct)
               armPkg::functAnd: ALUControl = armPkg::aluAnd;
               armPkg::functSub: ALUControl = armPkg::aluSub;
               armPkg::functAdd: ALUControl = armPkg::aluAdd;
               armPkg::functOrr: ALUControl = armPkg::aluOrr;
               default:          functKnown = 1'b0;  // Unlisted function has no effect
            endcase
            setFlags = functKnown & Instr[armPkg::sBit];
            RegW     = functKnown;
            FlagW[1] = setFlags;
            // Carry and overflow only from arithmetic
            FlagW[0] = setFlags & (ALUControl == armPkg::aluAdd ||
                                   ALUControl == armPkg::aluSub);
         end
         armPkg::opMemory:
         begin
            ALUSrc    = 1'b1;
            ImmSrc    = armPkg::immMem12;
            MemStrobe = 1'b1;
            if (Instr[armPkg::lBit])
            begin
               RegW     = 1'b1;   // LDR
               MemtoReg = 1'b1;
            end
            else
            begin
               MemW   = 1'b1;     // STR
               RegSrc = 2'b10;    // Store data from rd
            end
         end
         armPkg::opBranch:
         begin
            ALUSrc = 1'b1;
            ImmSrc = armPkg::immBranch24;
            RegSrc = 2'b01;       // Base is PC+8
            branch = 1'b1;
         end
         default: ;  // Op 11 unsupported
      endcase
   end

   // Branch or any register write aimed at R15 redirects the PC
   assign PCS = branch |
                (RegW & (Instr[armPkg::rdMsb:armPkg::rdLsb] == armPkg::pcRegIdx));

endmodule

// ==== logic/condLogic.sv ====
// Flag registers, condition check and gating of the write enables
`timescale 1ns/1ps

module condLogic (
   input  logic           clk,
   input  logic           reset,
   input  logic           PCReady,
   input  armPkg::cond_t  Cond,
   input  armPkg::flags_t ALUFlags,
   input  logic [1:0]     FlagW,
   input  logic           PCS,
   input  logic           RegW,
   input  logic           MemW,
   output logic           PCSrc,
   output logic           RegWrite,
   output logic           MemWrite
);

   logic [1:0]     nzFlags;
   logic [1:0]     cvFlags;
   armPkg::flags_t flags;      // State before the current instruction
   logic           condEx;
   logic           commit;     // Condition passed and core not stalled
   logic [1:0]     flagWrite;
   logic           neg, zero, carry, overflow, ge;

   // N and Z
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         nzFlags <= 2'b00;
      else if (flagWrite[1])
         nzFlags <= ALUFlags[3:2];
   end

   // C and V
   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         cvFlags <= 2'b00;
      else if (flagWrite[0])
         cvFlags <= ALUFlags[1:0];
   end

   assign flags = {nzFlags, cvFlags};
   assign {neg, zero, carry, overflow} = flags;
   assign ge = (neg == overflow);

   always_comb
   begin
      case (Cond)
         4'b0000:           condEx = zero;              // EQ
         4'b0001:           condEx = ~zero;             // NE
         4'b0010:           condEx = carry;             // CS
         4'b0011:           condEx = ~carry;            // CC
         4'b0100:           condEx = neg;               // MI
         4'b0101:           condEx = ~neg;              // PL
         4'b0110:           condEx = overflow;          // VS
         4'b0111:           condEx = ~overflow;         // VC
         4'b1000:           condEx = carry & ~zero;     // HI
         4'b1001:           condEx = ~carry | zero;     // LS
         4'b1010:           condEx = ge;                // GE
         4'b1011:           condEx = ~ge;               // LT
         4'b1100:           condEx = ~zero & ge;        // GT
         4'b1101:           condEx = zero | ~ge;        // LE
         armPkg::condAlways: condEx = 1'b1;
         default:           condEx = 1'b0;              // 1111 never executes
      endcase
   end

   // State changes only on a cycle that retires the instruction
   assign commit    = condEx & PCReady;
   assign flagWrite = FlagW & {2{commit}};
   assign RegWrite  = RegW & commit;
   assign MemWrite  = MemW & commit;
   assign PCSrc     = PCS & condEx;  // pcUnit applies the stall itself

endmodule

// ==== logic/pcUnit.sv ====
// Program counter register, PC+4 and PC+8 adders and next-PC selection
`timescale 1ns/1ps

module pcUnit (
   input  logic          clk,
   input  logic          reset,
   input  logic          PCReady,
   input  logic          PCSrc,
   input  armPkg::word_t Result,
   output armPkg::word_t PC,
   output armPkg::word_t PCPlus4,
   output armPkg::word_t PCPlus8
);

   armPkg::word_t pcNext;

   assign PCPlus4 = PC + armPkg::pcStep;
   assign PCPlus8 = PCPlus4 + armPkg::pcStep;  // Value R15 reads as
   assign pcNext  = PCSrc ? Result : PCPlus4;  // Taken branch or R15 write

   always_ff @(posedge clk, posedge reset)
   begin
      if (reset)
         PC <= '0;
      else if (PCReady)       // Hold during a stall
         PC <= pcNext;
   end

endmodule

// ==== logic/armCore.sv ====
// Top level of the single-cycle ARM core joining control, PC and datapath
`timescale 1ns/1ps

module armCore (
   input  logic          clk,
   input  logic          reset,
   output armPkg::word_t PC,
   input  armPkg::word_t Instr,
   output logic          MemWrite,
   output logic          MemStrobe,
   output armPkg::word_t ALUResult,   // Data address
   output armPkg::word_t WriteData,
   input  armPkg::word_t ReadData,
   input  logic          PCReady     // Low stalls the core
);

   logic [1:0]      flagW;
   logic            pcs, regW, memW;
   logic            memtoReg, aluSrc;
   armPkg::immSrc_t immSrc;
   armPkg::aluOp_t  aluControl;
   logic [1:0]      regSrc;
   logic            pcSrc, regWrite;
   armPkg::flags_t  aluFlags;
   armPkg::word_t   result;
   armPkg::word_t   pcPlus8;

   decoder dec (
      .Instr      (Instr),
      .FlagW      (flagW),
      .PCS        (pcs),
      .RegW       (regW),
      .MemW       (memW),
      .MemtoReg   (memtoReg),
      .ALUSrc     (aluSrc),
      .MemStrobe  (MemStrobe),
      .ImmSrc     (immSrc),
      .ALUControl (aluControl),
      .RegSrc     (regSrc)
   );

   condLogic cl (
      .clk      (clk),
      .reset    (reset),
      .PCReady  (PCReady),
      .Cond     (Instr[armPkg::condMsb:armPkg::condLsb]),
      .ALUFlags (aluFlags),
      .FlagW    (flagW),
      .PCS      (pcs),
      .RegW     (regW),
      .MemW     (memW),
      .PCSrc    (pcSrc),
      .RegWrite (regWrite),
      .MemWrite (MemWrite)
   );

   // PC+4 only feeds the next-PC choice inside pcUnit
   pcUnit pcu (
      .clk     (clk),
      .reset   (reset),
      .PCReady (PCReady),
      .PCSrc   (pcSrc),
      .Result  (result),
      .PC      (PC),
      .PCPlus4 (),
      .PCPlus8 (pcPlus8)
   );

   datapath dp (
      .clk        (clk),
      .Instr      (Instr),
      .ReadData   (ReadData),
      .PCPlus8    (pcPlus8),
      .RegWrite   (regWrite),
      .RegSrc     (regSrc),
      .ImmSrc     (immSrc),
      .ALUSrc     (aluSrc),
      .ALUControl (aluControl),
      .MemtoReg   (memtoReg),
      .ALUFlags   (aluFlags),
      .ALUResult  (ALUResult),
      .WriteData  (WriteData),
      .Result     (result)
   );

endmodule

// ==== testbench/armCoreTb.sv ====
// Testbench for armCore with trace-loaded ROM and RAM, random stalls and store checks
`timescale 1ns/1ps

module armCoreTb;

   localparam int    memWords     = 64;
   localparam int    resetCycles  = 3;
   localparam int    marginCycles = 40;
   localparam int    drainCycles  = 8;    // Watch for stray stores at the end
   localparam string traceFile    = "testbench/armTrace.txt";

   logic          clk;
   logic          reset;
   logic          PCReady;
   logic          MemWrite;
   logic          MemStrobe;
   armPkg::word_t PC, Instr, ALUResult, WriteData, ReadData;

   armPkg::word_t rom [0:memWords-1];
   armPkg::word_t ram [0:memWords-1];
   string         expName [$];   // Expected stores in program order
   armPkg::word_t expAddr [$];
   armPkg::word_t expData [$];

   integer seed;
   int     numInstr;
   int     storeIdx;             // Next expected store
   int     cycles;
   int     cycleLimit;
   int     testsPassed;
   int     testsFailed;
   int     otherErrors;
   bit     traceOk;
   bit     timedOut;

   armCore dut (
      .clk       (clk),
      .reset     (reset),
      .PC        (PC),
      .Instr     (Instr),
      .MemWrite  (MemWrite),
      .MemStrobe (MemStrobe),
      .ALUResult (ALUResult),
      .WriteData (WriteData),
      .ReadData  (ReadData),
      .PCReady   (PCReady)
   );

   // Both memories answer within the cycle
   assign Instr    = rom[PC[7:2]];
   assign ReadData = ram[ALUResult[7:2]];

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;  // 20 ns period
   end

   // Program words, initial data and expected stores from the trace
   task automatic loadTrace();
      int            fd;
      int            n;
      string         line;
      string         name;
      armPkg::word_t addr;
      armPkg::word_t data;
      for (int i = 0; i < memWords; i++)
      begin
         rom[i] = '0;
         ram[i] <= '0;
      end
      traceOk = 1'b0;
      fd = $fopen(traceFile, "r");
      if (fd == 0)
      begin
         $display("Cannot open trace file %s", traceFile);
         return;
      end
      while (!$feof(fd))
      begin
         n = $fgets(line, fd);
         if (n > 0)
         begin
            case (line.getc(0))
               "I":
               begin
                  n = $sscanf(line, "I %h", data);
                  if (numInstr < memWords)
                     rom[numInstr] = data;  // Word index is PC / 4
                  numInstr++;
               end
               "D":
               begin
                  n = $sscanf(line, "D %h %h", addr, data);
                  ram[addr[7:2]] <= data;
               end
               "W":
               begin
                  n = $sscanf(line, "W %s %h %h", name, addr, data);
                  expName.push_back(name);
                  expAddr.push_back(addr);
                  expData.push_back(data);
               end
               default: ;  // Comment or blank line
            endcase
         end
      end
      $fclose(fd);
      traceOk = (numInstr > 0 && numInstr <= memWords && expName.size() > 0);
      if (!traceOk)
         $display("Trace holds no program, an oversized program or no expected stores");
   endtask

   task automatic checkAddr(input string name, input armPkg::word_t expected,
                            input armPkg::word_t actual, output bit ok);
      ok = (actual === expected);
      if (!ok)
         $display("** Error %s: address expected %08h, actual %08h", name, expected, actual);
   endtask

   task automatic checkWord(input string name, input armPkg::word_t expected,
                            input armPkg::word_t actual, output bit ok);
      ok = (actual === expected);
      if (!ok)
         $display("** Error %s: data expected %08h, actual %08h", name, expected, actual);
   endtask

   // One observed store against the next record
   task automatic checkStore();
      bit addrOk;
      bit dataOk;
      if (!MemStrobe)
      begin
         $display("MemWrite high without MemStrobe at PC %08h", PC);
         otherErrors++;
      end
      if (storeIdx >= expName.size())
      begin
         $display("Unexpected store of %08h to %08h after the last expected store",
                  WriteData, ALUResult);
         otherErrors++;
         return;
      end
      checkAddr(expName[storeIdx], expAddr[storeIdx], ALUResult, addrOk);
      checkWord(expName[storeIdx], expData[storeIdx], WriteData, dataOk);
      if (addrOk && dataOk)
      begin
         $display("%s ok, %08h to %08h", expName[storeIdx], WriteData, ALUResult);
         testsPassed++;
      end
      else
         testsFailed++;
      storeIdx++;
   endtask

   // Falling edge to falling edge, outputs sampled at the rising edge
   task automatic runCycle(input logic ready);
      PCReady = ready;
      @(posedge clk);
      cycles++;
      if (MemWrite)
      begin
         checkStore();
         ram[ALUResult[7:2]] <= WriteData;  // RAM write on the rising edge
      end
      @(negedge clk);
   endtask

   initial
   begin
      seed        = 32'hfa4efce6;
      reset       = 1'b1;
      PCReady     = 1'b0;
      numInstr    = 0;
      storeIdx    = 0;
      cycles      = 0;
      testsPassed = 0;
      testsFailed = 0;
      otherErrors = 0;
      timedOut    = 1'b0;
      loadTrace();
      cycleLimit = 8 * numInstr + resetCycles + marginCycles;
      repeat (resetCycles) @(negedge clk);
      reset = 1'b0;
      // Ready in about three cycles of four
      while (traceOk && !timedOut && storeIdx < expName.size())
      begin
         runCycle(($random(seed) & 3) != 0);
         if (cycles >= cycleLimit)
            timedOut = 1'b1;
      end
      if (timedOut)
         $display("Timeout after %0d cycles with %0d of %0d stores seen",
                  cycles, storeIdx, expName.size());
      if (traceOk && !timedOut)
         repeat (drainCycles) runCycle(1'b1);  // Program spins, no more stores
      $display("Tests: %0d passed, %0d failed, %0d not reached, %0d other errors",
               testsPassed, testsFailed, expName.size() - storeIdx, otherErrors);
      if (traceOk && !timedOut && testsFailed == 0 && otherErrors == 0 &&
          storeIdx == expName.size())
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

// ==== testbench/armTrace.txt ====
# I <word hex>: program word, one per line from address 0 | D <byte addr> <word>: data RAM
# W <test> <byte addr> <word>: expected store, listed in the order the program makes them
I e04f000f  # 00 sub r0, pc, pc
I e2801005  # 04 add r1, r0, #5
I e380200c  # 08 orr r2, r0, #12
I e0813002  # 0c add r3, r1, r2
I e5803040  # 10 str r3, [r0, #0x40]
I e2424003  # 14 sub r4, r2, #3
I e5804044  # 18 str r4, [r0, #0x44]
I e0415002  # 1c sub r5, r1, r2
I e5805048  # 20 str r5, [r0, #0x48]
I e202600a  # 24 and r6, r2, #10
I e580604c  # 28 str r6, [r0, #0x4c]
I e0057001  # 2c and r7, r5, r1
I e5807050  # 30 str r7, [r0, #0x50]
I e1878002  # 34 orr r8, r7, r2
I e5808054  # 38 str r8, [r0, #0x54]
I e5909080  # 3c ldr r9, [r0, #0x80]
I e089a001  # 40 add r10, r9, r1
I e580a058  # 44 str r10, [r0, #0x58]
I e251b005  # 48 subs r11, r1, #5
I 0580305c  # 4c streq r3, [r0, #0x5c]
I 15804060  # 50 strne r4, [r0, #0x60]
I e280c001  # 54 add r12, r0, #1
I 0580c060  # 58 streq r12, [r0, #0x60]
I e590b084  # 5c ldr r11, [r0, #0x84]
I e09bb001  # 60 adds r11, r11, r1
I 6580b064  # 64 strvs r11, [r0, #0x64]
I 75801064  # 68 strvc r1, [r0, #0x64]
I ea000000  # 6c b 0x74
I e5801068  # 70 str r1, [r0, #0x68]
I e280c003  # 74 add r12, r0, #3
I e04fd00f  # 78 sub r13, pc, pc
I e08dd002  # 7c add r13, r13, r2
I e580d06c  # 80 str r13, [r0, #0x6c]
I e25cc001  # 84 subs r12, r12, #1
I 1afffffb  # 88 bne 0x7c
I e580f070  # 8c str pc, [r0, #0x70]
I e28ff004  # 90 add pc, pc, #4
I e5801074  # 94 str r1, [r0, #0x74]
I e5802074  # 98 str r2, [r0, #0x74]
I e5804074  # 9c str r4, [r0, #0x74]
I eafffffe  # a0 b 0xa0
D 80 12345678
D 84 7fffffff
W addReg 40 00000011
W subImm 44 00000009
W subReg 48 fffffff9
W andImm 4c 00000008
W andReg 50 00000001
W orrReg 54 0000000d
W ldrAdd 58 1234567d
W strEq 5c 00000011
W noSFlags 60 00000001
W strVs 64 80000004
W loopPass1 6c 0000000c
W loopPass2 6c 00000018
W loopPass3 6c 00000024
W strPc 70 00000094
W addPc 74 00000009

// ==== sim.f ====
logic/armPkg.sv
logic/alu.sv
logic/regFile.sv
logic/datapath.sv
logic/decoder.sv
logic/condLogic.sv
logic/pcUnit.sv
logic/armCore.sv
testbench/armCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the ARM core testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --top-module armCoreTb -f sim.f -Mdir obj_dir
	./obj_dir/VarmCoreTb | tee sim.log
	@if grep -q '\*\* FAIL \*\*' sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q '\*\* PASS \*\*' sim.log; then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log
